// File: src/exu_pkg.sv
/*
  shared definitions for the execute front of the in-order core
  field positions inside the packed decode result, alu mode codes,
  divider step count and the typedefs used on every unit port
  import with exu_pkg::* in the module header
*/
`default_nettype none

package exu_pkg;

	localparam int IBUS_TID_WIDTH = 8; // instruction id width

	// type flags in the low 16 bits of the decode result
	localparam int INST_FLAG_REM_SID = 0;
	localparam int INST_FLAG_DIV_SID = 1;
	localparam int INST_FLAG_MUL_SID = 2;
	localparam int INST_FLAG_STORE_SID = 3;
	localparam int INST_FLAG_LOAD_SID = 4;
	localparam int INST_FLAG_CSR_RW_SID = 5;
	localparam int INST_FLAG_ILLEGAL_SID = 15;

	localparam int FU_OP_BASE = 16; // op info starts above the flags

	// op info fields, relative to FU_OP_BASE
	localparam int ALU_OP_MSG_OP2_SID = 0;
	localparam int ALU_OP_MSG_OP1_SID = 32;
	localparam int ALU_OP_MSG_OP_MODE_SID = 64;
	localparam int LSU_OP_MSG_OFS_SID = 0;
	localparam int LSU_OP_MSG_BASE_SID = 32;
	localparam int LSU_OP_MSG_TYPE_SID = 64;
	localparam int LSU_OP_MSG_DIN_SID = 67;
	localparam int CSR_OP_MSG_ADDR_SID = 34;
	localparam int MD_OP_MSG_RES_SEL_SID = 0;
	localparam int MD_OP_MSG_OP_B_SID = 1;
	localparam int MD_OP_MSG_OP_A_SID = 34;

	localparam logic [3:0] OP_MODE_ADD = 4'd0;
	localparam logic [3:0] OP_MODE_SUB = 4'd1;
	localparam logic [3:0] OP_MODE_EQU = 4'd2;
	localparam logic [3:0] OP_MODE_NEQU = 4'd3;
	localparam logic [3:0] OP_MODE_SGN_LT = 4'd4;
	localparam logic [3:0] OP_MODE_SGN_GET = 4'd5; // signed >=
	localparam logic [3:0] OP_MODE_USGN_LT = 4'd6;
	localparam logic [3:0] OP_MODE_USGN_GET = 4'd7; // unsigned >=
	localparam logic [3:0] OP_MODE_XOR = 4'd8;
	localparam logic [3:0] OP_MODE_OR = 4'd9;
	localparam logic [3:0] OP_MODE_AND = 4'd10;
	localparam logic [3:0] OP_MODE_LG_LSH = 4'd11;
	localparam logic [3:0] OP_MODE_LG_RSH = 4'd12;
	localparam logic [3:0] OP_MODE_ATH_RSH = 4'd13; // highest legal mode

	localparam int DIV_STEPS = 33; // one quotient bit per cycle

	typedef logic [31:0] word_t;
	typedef logic [32:0] mdop_t; // already sign or zero extended
	typedef logic [IBUS_TID_WIDTH-1:0] inst_id_t;
	typedef logic [3:0] alu_mode_t;
	typedef logic [2:0] ls_type_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [127:0] fetch_data_t; // {pc, predecode, instruction}
	typedef logic [146:0] fetch_msg_t; // {branch prediction, error code}
	typedef logic [143:0] dcd_res_t; // {op info, type flags}

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

endpackage

`default_nettype wire

// File: src/dispatch.sv
/*
  dispatch of one issued instruction, purely combinational
  every instruction goes to the bru; alu, csr, lsu, multiplier
  and divider get their slice of the op info in the same cycle
  loads and stores use the alu as address adder
*/
`timescale 1ns/1ps
`default_nettype none

module dispatch
	import exu_pkg::*;
(
	input wire fetch_data_t issue_data,
	input wire fetch_msg_t issue_msg,
	input wire dcd_res_t issue_dcd_res,
	input wire inst_id_t issue_id,
	input wire issue_first_after_rst,
	input wire issue_valid,
	output logic issue_ready,
	output fetch_data_t bru_data,
	output fetch_msg_t bru_msg,
	output dcd_res_t bru_dcd_res,
	output inst_id_t bru_id,
	output logic bru_first_after_rst,
	output logic bru_valid,
	input wire bru_ready,
	output alu_mode_t alu_mode,
	output word_t alu_op1,
	output word_t alu_op2,
	output inst_id_t alu_tid,
	output logic alu_use_res,
	output logic alu_valid,
	output csr_addr_t csr_addr,
	output inst_id_t csr_tid,
	output logic csr_valid,
	output logic lsu_ls_sel,
	output ls_type_t lsu_ls_type,
	output word_t lsu_ls_din,
	output inst_id_t lsu_inst_id,
	output logic lsu_valid,
	input wire lsu_ready,
	output mdop_t mul_op_a,
	output mdop_t mul_op_b,
	output logic mul_res_sel,
	output inst_id_t mul_inst_id,
	output logic mul_valid,
	input wire mul_ready,
	output mdop_t div_op_a,
	output mdop_t div_op_b,
	output logic div_rem_sel,
	output inst_id_t div_inst_id,
	output logic div_valid,
	input wire div_ready
);

	logic is_illegal, is_ls, is_mul, is_div, is_csr;
	logic fu_ready, legal_ls, unit_go;

	assign is_illegal = issue_dcd_res[INST_FLAG_ILLEGAL_SID];
	assign is_ls = issue_dcd_res[INST_FLAG_STORE_SID] | issue_dcd_res[INST_FLAG_LOAD_SID];
	assign is_mul = issue_dcd_res[INST_FLAG_MUL_SID];
	assign is_div = issue_dcd_res[INST_FLAG_REM_SID] | issue_dcd_res[INST_FLAG_DIV_SID];
	assign is_csr = issue_dcd_res[INST_FLAG_CSR_RW_SID];
	assign legal_ls = ~is_illegal & is_ls;

	// illegal instructions need none of lsu, mul, div
	assign fu_ready = is_illegal |
		((~is_ls | lsu_ready) & (~is_mul | mul_ready) & (~is_div | div_ready));
	assign issue_ready = bru_ready & fu_ready;
	assign unit_go = issue_valid & bru_ready & ~is_illegal; // unit valids imply a transfer

	assign bru_data = issue_data; // bru sees everything untouched
	assign bru_msg = issue_msg;
	assign bru_dcd_res = issue_dcd_res;
	assign bru_id = issue_id;
	assign bru_first_after_rst = issue_first_after_rst;
	assign bru_valid = issue_valid & fu_ready;

	// loads and stores compute base + offset on the alu
	assign alu_mode = legal_ls ? OP_MODE_ADD :
		issue_dcd_res[FU_OP_BASE+ALU_OP_MSG_OP_MODE_SID +: $bits(alu_mode_t)];
	assign alu_op1 = legal_ls ? issue_dcd_res[FU_OP_BASE+LSU_OP_MSG_BASE_SID +: 32] :
		issue_dcd_res[FU_OP_BASE+ALU_OP_MSG_OP1_SID +: 32];
	assign alu_op2 = legal_ls ? issue_dcd_res[FU_OP_BASE+LSU_OP_MSG_OFS_SID +: 32] :
		issue_dcd_res[FU_OP_BASE+ALU_OP_MSG_OP2_SID +: 32];
	assign alu_tid = issue_id;
	assign alu_use_res = ~is_ls; // an address is not the instruction result
	assign alu_valid = issue_valid & issue_ready & ~(~is_illegal & is_csr); // csr skips the alu

	assign csr_addr = issue_dcd_res[FU_OP_BASE+CSR_OP_MSG_ADDR_SID +: $bits(csr_addr_t)];
	assign csr_tid = issue_id;
	assign csr_valid = issue_valid & ~is_illegal & is_csr;

	assign lsu_ls_sel = issue_dcd_res[INST_FLAG_STORE_SID]; // 1 for store
	assign lsu_ls_type = issue_dcd_res[FU_OP_BASE+LSU_OP_MSG_TYPE_SID +: $bits(ls_type_t)];
	assign lsu_ls_din = issue_dcd_res[FU_OP_BASE+LSU_OP_MSG_DIN_SID +: 32];
	assign lsu_inst_id = issue_id;
	assign lsu_valid = unit_go & is_ls;

	assign mul_op_a = issue_dcd_res[FU_OP_BASE+MD_OP_MSG_OP_A_SID +: $bits(mdop_t)];
	assign mul_op_b = issue_dcd_res[FU_OP_BASE+MD_OP_MSG_OP_B_SID +: $bits(mdop_t)];
	assign mul_res_sel = issue_dcd_res[FU_OP_BASE+MD_OP_MSG_RES_SEL_SID]; // 1 for high word
	assign mul_inst_id = issue_id;
	assign mul_valid = unit_go & is_mul;

	assign div_op_a = mul_op_a; // same op info field as the multiplier
	assign div_op_b = mul_op_b;
	assign div_rem_sel = issue_dcd_res[INST_FLAG_REM_SID];
	assign div_inst_id = issue_id;
	assign div_valid = unit_go & is_div;

endmodule

`default_nettype wire

// File: src/alu.sv
/*
  single-cycle alu, result registered one cycle after in_valid
  use_res travels with the result so that the arbiter can tell
  register results from load/store addresses
*/
`timescale 1ns/1ps
`default_nettype none

module alu
	import exu_pkg::*;
(
	input wire aclk,
	input wire arst_n,
	input wire in_valid,
	input wire alu_mode_t mode,
	input wire word_t op1,
	input wire word_t op2,
	input wire inst_id_t tid,
	input wire use_res,
	output logic res_valid,
	output word_t res_data,
	output inst_id_t res_tid,
	output logic res_use
);

	word_t res_nxt;
	logic [4:0] shamt;

	assign shamt = op2[4:0]; // rv32 shift amount

	always_comb begin
		case (mode)
			OP_MODE_ADD: res_nxt = op1 + op2;
			OP_MODE_SUB: res_nxt = op1 - op2;
			OP_MODE_EQU: res_nxt = word_t'(op1 == op2);
			OP_MODE_NEQU: res_nxt = word_t'(op1 != op2);
			OP_MODE_SGN_LT: res_nxt = word_t'($signed(op1) < $signed(op2));
			OP_MODE_SGN_GET: res_nxt = word_t'($signed(op1) >= $signed(op2));
			OP_MODE_USGN_LT: res_nxt = word_t'(op1 < op2);
			OP_MODE_USGN_GET: res_nxt = word_t'(op1 >= op2);
			OP_MODE_XOR: res_nxt = op1 ^ op2;
			OP_MODE_OR: res_nxt = op1 | op2;
			OP_MODE_AND: res_nxt = op1 & op2;
			OP_MODE_LG_LSH: res_nxt = op1 << shamt;
			OP_MODE_LG_RSH: res_nxt = op1 >> shamt;
			OP_MODE_ATH_RSH: res_nxt = word_t'($signed(op1) >>> shamt);
			default: res_nxt = '0; // codes 14, 15 unused
		endcase
	end

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n)
			res_valid <= 1'b0;
		else
			res_valid <= in_valid; // one-cycle pulse, never stalled
	end

	always_ff @(posedge aclk) begin
		if (in_valid) begin
			res_data <= res_nxt;
			res_tid <= tid;
			res_use <= use_res;
		end
	end

	a_mode_legal: assert property (@(posedge aclk) disable iff (!arst_n)
		in_valid |-> mode <= OP_MODE_ATH_RSH);

endmodule

`default_nettype wire

// File: src/mul_unit.sv
/*
  two-stage signed 33x33 multiplier
  stage 1 holds the operands, stage 2 the selected half of the
  66-bit product until the arbiter grants it
  up to two instructions in flight, result two cycles after accept
*/
`timescale 1ns/1ps
`default_nettype none

module mul_unit
	import exu_pkg::*;
(
	input wire aclk,
	input wire arst_n,
	input wire in_valid,
	input wire mdop_t op_a,
	input wire mdop_t op_b,
	input wire res_sel,
	input wire inst_id_t inst_id,
	output logic in_ready,
	output logic res_valid,
	output word_t res_data,
	output inst_id_t res_tid,
	input wire grant
);

	logic s1_valid, s1_sel, s2_free;
	mdop_t s1_a, s1_b;
	inst_id_t s1_tid;
	logic signed [65:0] prod;

	assign s2_free = ~res_valid | grant; // stage 2 empty or leaving
	assign in_ready = ~s1_valid | s2_free;
	assign prod = $signed(s1_a) * $signed(s1_b);

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			if (in_ready)
				s1_valid <= in_valid;
			if (s2_free)
				res_valid <= s1_valid;
		end
	end

	always_ff @(posedge aclk) begin
		if (in_valid && in_ready) begin
			s1_a <= op_a;
			s1_b <= op_b;
			s1_sel <= res_sel;
			s1_tid <= inst_id;
		end
		if (s1_valid && s2_free) begin
			res_data <= s1_sel ? prod[63:32] : prod[31:0]; // mulh* vs mul
			res_tid <= s1_tid;
		end
	end

	// result must hold while the arbiter serves someone else
	a_hold: assert property (@(posedge aclk) disable iff (!arst_n)
		res_valid && !grant |=> res_valid && $stable(res_data) && $stable(res_tid));

endmodule

`default_nettype wire

// File: src/div_unit.sv
/*
  iterative radix-2 divider for div, divu, rem, remu
  works on magnitudes for DIV_STEPS cycles, then applies the signs
  divide by zero gives all ones and the dividend as remainder,
  the most negative / -1 case falls out of the 33-bit operands
  accepts only in idle, holds the result in done until granted
*/
`timescale 1ns/1ps
`default_nettype none

module div_unit
	import exu_pkg::*;
(
	input wire aclk,
	input wire arst_n,
	input wire in_valid,
	input wire mdop_t op_a,
	input wire mdop_t op_b,
	input wire rem_sel,
	input wire inst_id_t inst_id,
	output logic in_ready,
	output logic res_valid,
	output word_t res_data,
	output inst_id_t res_tid,
	input wire grant
);

	div_state_t state;
	logic [5:0] cnt;
	mdop_t dvs, quot, rem; // divisor, quotient and partial remainder magnitudes
	mdop_t a_mag, b_mag, q_fix, r_fix;
	logic q_neg, r_neg, sel_rem;
	logic [33:0] shifted;
	logic [34:0] diff;

	assign in_ready = state == DIV_IDLE;
	assign res_valid = state == DIV_DONE;

	assign a_mag = op_a[32] ? -op_a : op_a;
	assign b_mag = op_b[32] ? -op_b : op_b;
	assign shifted = {rem, quot[32]}; // bring down next dividend bit
	assign diff = {1'b0, shifted} - {2'b00, dvs};

	assign q_fix = q_neg ? -quot : quot;
	assign r_fix = r_neg ? -rem : rem; // remainder takes the dividend sign
	assign res_data = sel_rem ? r_fix[31:0] : q_fix[31:0];

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= DIV_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				DIV_IDLE: begin
					cnt <= '0;
					if (in_valid)
						state <= DIV_RUN;
				end
				DIV_RUN: begin
					cnt <= cnt + 6'd1;
					if (cnt == DIV_STEPS - 1)
						state <= DIV_DONE;
				end
				DIV_DONE: begin
					if (grant)
						state <= DIV_IDLE;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (in_valid && in_ready) begin
			dvs <= b_mag;
			quot <= a_mag; // dividend shifts out as quotient shifts in
			rem <= '0;
			q_neg <= (op_a[32] ^ op_b[32]) & (|op_b); // zero divisor keeps all ones
			r_neg <= op_a[32];
			sel_rem <= rem_sel;
			res_tid <= inst_id;
		end else if (state == DIV_RUN) begin
			quot <= {quot[31:0], ~diff[34]};
			rem <= diff[34] ? shifted[32:0] : diff[32:0]; // restore on borrow
		end
	end

	// once accepted, nothing else gets in for the whole computation
	a_no_accept_busy: assert property (@(posedge aclk) disable iff (!arst_n)
		in_valid && in_ready |=> !in_ready [*DIV_STEPS]);

endmodule

`default_nettype wire

// File: src/wb_arbiter.sv
/*
  merges alu, multiplier and divider results onto one writeback
  port, fixed priority alu > mul > div
  alu results without use_res are addresses and go to addr instead
  outputs registered, writeback one cycle after the grant
*/
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
	import exu_pkg::*;
(
	input wire aclk,
	input wire arst_n,
	input wire alu_res_valid,
	input wire word_t alu_res_data,
	input wire inst_id_t alu_res_tid,
	input wire alu_res_use,
	input wire mul_res_valid,
	input wire word_t mul_res_data,
	input wire inst_id_t mul_res_tid,
	output logic mul_grant,
	input wire div_res_valid,
	input wire word_t div_res_data,
	input wire inst_id_t div_res_tid,
	output logic div_grant,
	output logic wb_valid,
	output word_t wb_data,
	output inst_id_t wb_tid,
	output logic addr_valid,
	output word_t addr
);

	logic alu_wb;

	assign alu_wb = alu_res_valid & alu_res_use; // alu is never made to wait
	assign mul_grant = mul_res_valid & ~alu_wb;
	assign div_grant = div_res_valid & ~alu_wb & ~mul_res_valid;

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			addr_valid <= 1'b0;
		end else begin
			wb_valid <= alu_wb | mul_grant | div_grant;
			addr_valid <= alu_res_valid & ~alu_res_use; // separate path from writeback
		end
	end

	always_ff @(posedge aclk) begin
		addr <= alu_res_data;
		if (alu_wb) begin
			wb_data <= alu_res_data;
			wb_tid <= alu_res_tid;
		end else if (mul_grant) begin
			wb_data <= mul_res_data;
			wb_tid <= mul_res_tid;
		end else begin
			wb_data <= div_res_data;
			wb_tid <= div_res_tid;
		end
	end

	// lowest priority result waits unchanged until its grant
	a_div_hold: assert property (@(posedge aclk) disable iff (!arst_n)
		div_res_valid && !div_grant |=>
			div_res_valid && $stable(div_res_data) && $stable(div_res_tid));

endmodule

`default_nettype wire

// File: src/exu_top.sv
/*
  execute front top level
  dispatch feeds the alu, multiplier and divider, whose results
  meet in the writeback arbiter; bru, csr and lsu stay outside
  and their dispatch ports are brought out here
*/
`timescale 1ns/1ps
`default_nettype none

module exu_top
	import exu_pkg::*;
(
	input wire aclk,
	input wire arst_n,
	input wire fetch_data_t issue_data,
	input wire fetch_msg_t issue_msg,
	input wire dcd_res_t issue_dcd_res,
	input wire inst_id_t issue_id,
	input wire issue_first_after_rst,
	input wire issue_valid,
	output logic issue_ready,
	output fetch_data_t bru_data,
	output fetch_msg_t bru_msg,
	output dcd_res_t bru_dcd_res,
	output inst_id_t bru_id,
	output logic bru_first_after_rst,
	output logic bru_valid,
	input wire bru_ready,
	output csr_addr_t csr_addr,
	output inst_id_t csr_tid,
	output logic csr_valid,
	output logic lsu_ls_sel,
	output ls_type_t lsu_ls_type,
	output word_t lsu_ls_din,
	output inst_id_t lsu_inst_id,
	output logic lsu_valid,
	input wire lsu_ready,
	output logic wb_valid,
	output word_t wb_data,
	output inst_id_t wb_tid,
	output logic addr_valid,
	output word_t addr
);

	alu_mode_t alu_mode;
	word_t alu_op1, alu_op2;
	inst_id_t alu_tid;
	logic alu_use_res, alu_valid;
	mdop_t mul_op_a, mul_op_b, div_op_a, div_op_b;
	logic mul_res_sel, mul_valid, mul_ready;
	logic div_rem_sel, div_valid, div_ready;
	inst_id_t mul_inst_id, div_inst_id;
	logic alu_res_valid, alu_res_use, mul_res_valid, div_res_valid;
	word_t alu_res_data, mul_res_data, div_res_data;
	inst_id_t alu_res_tid, mul_res_tid, div_res_tid;
	logic mul_grant, div_grant;

	dispatch u_dispatch (.*); // port names match one to one

	alu u_alu (
		.aclk(aclk), .arst_n(arst_n),
		.in_valid(alu_valid), .mode(alu_mode), .op1(alu_op1), .op2(alu_op2),
		.tid(alu_tid), .use_res(alu_use_res),
		.res_valid(alu_res_valid), .res_data(alu_res_data),
		.res_tid(alu_res_tid), .res_use(alu_res_use)
	);

	mul_unit u_mul (
		.aclk(aclk), .arst_n(arst_n),
		.in_valid(mul_valid), .op_a(mul_op_a), .op_b(mul_op_b),
		.res_sel(mul_res_sel), .inst_id(mul_inst_id), .in_ready(mul_ready),
		.res_valid(mul_res_valid), .res_data(mul_res_data),
		.res_tid(mul_res_tid), .grant(mul_grant)
	);

	div_unit u_div (
		.aclk(aclk), .arst_n(arst_n),
		.in_valid(div_valid), .op_a(div_op_a), .op_b(div_op_b),
		.rem_sel(div_rem_sel), .inst_id(div_inst_id), .in_ready(div_ready),
		.res_valid(div_res_valid), .res_data(div_res_data),
		.res_tid(div_res_tid), .grant(div_grant)
	);

	wb_arbiter u_arb (
		.aclk(aclk), .arst_n(arst_n),
		.alu_res_valid(alu_res_valid), .alu_res_data(alu_res_data),
		.alu_res_tid(alu_res_tid), .alu_res_use(alu_res_use),
		.mul_res_valid(mul_res_valid), .mul_res_data(mul_res_data),
		.mul_res_tid(mul_res_tid), .mul_grant(mul_grant),
		.div_res_valid(div_res_valid), .div_res_data(div_res_data),
		.div_res_tid(div_res_tid), .div_grant(div_grant),
		.wb_valid(wb_valid), .wb_data(wb_data), .wb_tid(wb_tid),
		.addr_valid(addr_valid), .addr(addr)
	);

	// dispatch has no clock, so its unit exclusivity is checked here
	a_one_unit: assert property (@(posedge aclk) disable iff (!arst_n)
		$onehot0({lsu_valid, mul_valid, div_valid}));

endmodule

`default_nettype wire

// File: tests/tb_exu.sv
/*
  testbench for the execute front
  issues alu, mul, div, load/store, csr and illegal instructions through
  the dispatch port, keeps the expected results per id and compares every
  writeback and every address result against a reference model
*/
`timescale 1ns/1ps
`default_nettype none

module tb_exu
	import exu_pkg::*;
();

	logic aclk, arst_n;
	fetch_data_t issue_data, bru_data;
	fetch_msg_t issue_msg, bru_msg;
	dcd_res_t issue_dcd_res, bru_dcd_res;
	inst_id_t issue_id, bru_id, csr_tid, lsu_inst_id, wb_tid;
	logic issue_first_after_rst, issue_valid, issue_ready;
	logic bru_first_after_rst, bru_valid, bru_ready;
	csr_addr_t csr_addr;
	logic csr_valid, lsu_ls_sel, lsu_valid, lsu_ready;
	ls_type_t lsu_ls_type;
	word_t lsu_ls_din, wb_data, addr;
	logic wb_valid, addr_valid;

	word_t alu_exp [inst_id_t]; // alu results per id come back first
	word_t unit_exp [inst_id_t]; // mul or div result
	word_t addr_q [$]; // address results come back in issue order
	inst_id_t next_id;

	exu_top DUT (.*);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [159:0] got,
		input logic [159:0] want);
		if (got !== want)
			fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, want));
	endtask

	function automatic word_t exp_result(input alu_mode_t mode, input word_t a, input word_t b);
		word_t sa, sb;
		logic [4:0] sh;
		sa = a ^ 32'h8000_0000; // bias the sign so an unsigned compare orders signed values
		sb = b ^ 32'h8000_0000;
		sh = b[4:0];
		case (mode)
			OP_MODE_ADD: return a + b;
			OP_MODE_SUB: return a + ~b + 32'd1;
			OP_MODE_EQU: return word_t'(a == b);
			OP_MODE_NEQU: return word_t'(a != b);
			OP_MODE_SGN_LT: return word_t'(sa < sb);
			OP_MODE_SGN_GET: return word_t'(!(sa < sb));
			OP_MODE_USGN_LT: return word_t'(a < b);
			OP_MODE_USGN_GET: return word_t'(!(a < b));
			OP_MODE_XOR: return a ^ b;
			OP_MODE_OR: return a | b;
			OP_MODE_AND: return a & b;
			OP_MODE_LG_LSH: return a << sh;
			OP_MODE_LG_RSH: return a >> sh;
			OP_MODE_ATH_RSH: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			default: return '0;
		endcase
	endfunction

	function automatic word_t mul_ref(input mdop_t a, input mdop_t b, input logic hi);
		longint sa, sb, p;
		sa = $signed(a);
		sb = $signed(b);
		p = sa * sb; // low 64 bits of the product are all that matter
		return hi ? p[63:32] : p[31:0];
	endfunction

	function automatic word_t div_ref(input mdop_t a, input mdop_t b, input logic rem);
		longint sa, sb;
		sa = $signed(a);
		sb = $signed(b);
		if (sb == 0)
			return rem ? a[31:0] : 32'hffff_ffff; // risc-v divide by zero
		return rem ? word_t'(sa % sb) : word_t'(sa / sb); // both truncate toward zero
	endfunction

	function automatic mdop_t ext(input word_t v, input logic sgn);
		return {sgn & v[31], v};
	endfunction

	function automatic dcd_res_t alu_dcd(input alu_mode_t mode, input word_t op1,
		input word_t op2);
		dcd_res_t d;
		d = '0;
		d[FU_OP_BASE+ALU_OP_MSG_OP2_SID +: 32] = op2;
		d[FU_OP_BASE+ALU_OP_MSG_OP1_SID +: 32] = op1;
		d[FU_OP_BASE+ALU_OP_MSG_OP_MODE_SID +: 4] = mode;
		return d;
	endfunction

	function automatic dcd_res_t md_dcd(input int flag, input mdop_t a, input mdop_t b,
		input logic sel);
		dcd_res_t d;
		d = '0;
		d[flag] = 1'b1;
		d[FU_OP_BASE+MD_OP_MSG_RES_SEL_SID] = sel;
		d[FU_OP_BASE+MD_OP_MSG_OP_B_SID +: 33] = b;
		d[FU_OP_BASE+MD_OP_MSG_OP_A_SID +: 33] = a;
		return d;
	endfunction

	function automatic dcd_res_t ls_dcd(input logic store, input word_t base, input word_t ofs,
		input ls_type_t kind, input word_t din);
		dcd_res_t d;
		d = '0;
		d[store ? INST_FLAG_STORE_SID : INST_FLAG_LOAD_SID] = 1'b1;
		d[FU_OP_BASE+LSU_OP_MSG_OFS_SID +: 32] = ofs;
		d[FU_OP_BASE+LSU_OP_MSG_BASE_SID +: 32] = base;
		d[FU_OP_BASE+LSU_OP_MSG_TYPE_SID +: 3] = kind;
		d[FU_OP_BASE+LSU_OP_MSG_DIN_SID +: 32] = din;
		return d;
	endfunction

	// checks the unit strobes of the transfer cycle and books the expected results
	task automatic note_transfer(input dcd_res_t d, input inst_id_t id);
		logic ill, ls_f, legal_ls, csr, mul, dv;
		alu_mode_t m;
		word_t a, b;
		mdop_t ma, mb;
		ill = d[INST_FLAG_ILLEGAL_SID];
		ls_f = d[INST_FLAG_LOAD_SID] | d[INST_FLAG_STORE_SID];
		legal_ls = ~ill & ls_f;
		csr = ~ill & d[INST_FLAG_CSR_RW_SID];
		mul = ~ill & d[INST_FLAG_MUL_SID];
		dv = ~ill & (d[INST_FLAG_DIV_SID] | d[INST_FLAG_REM_SID]);
		ma = d[FU_OP_BASE+MD_OP_MSG_OP_A_SID +: 33];
		mb = d[FU_OP_BASE+MD_OP_MSG_OP_B_SID +: 33];
		check_val("bru_valid", word_t'(bru_valid), 1);
		check_val("bru_id", word_t'(bru_id), word_t'(id));
		check_val("bru_data", bru_data, issue_data); // bru gets the instruction untouched
		check_val("bru_msg", bru_msg, issue_msg);
		check_val("bru_dcd_res", bru_dcd_res, d);
		check_val("bru_first_after_rst", bru_first_after_rst, issue_first_after_rst);
		check_val("lsu_valid", word_t'(lsu_valid), word_t'(legal_ls));
		check_val("csr_valid", word_t'(csr_valid), word_t'(csr));
		check_val("mul_valid", word_t'(DUT.mul_valid), word_t'(mul));
		check_val("div_valid", word_t'(DUT.div_valid), word_t'(dv));
		if (legal_ls) begin
			check_val("lsu_ls_sel", word_t'(lsu_ls_sel), word_t'(d[INST_FLAG_STORE_SID]));
			check_val("lsu_ls_type", word_t'(lsu_ls_type),
				word_t'(d[FU_OP_BASE+LSU_OP_MSG_TYPE_SID +: 3]));
			check_val("lsu_ls_din", lsu_ls_din, d[FU_OP_BASE+LSU_OP_MSG_DIN_SID +: 32]);
			check_val("lsu_inst_id", word_t'(lsu_inst_id), word_t'(id));
		end
		if (csr) begin
			check_val("csr_addr", word_t'(csr_addr),
				word_t'(d[FU_OP_BASE+CSR_OP_MSG_ADDR_SID +: 12]));
			check_val("csr_tid", word_t'(csr_tid), word_t'(id));
		end else begin // alu runs for everything but csr
			m = legal_ls ? OP_MODE_ADD : d[FU_OP_BASE+ALU_OP_MSG_OP_MODE_SID +: 4];
			a = d[FU_OP_BASE+(legal_ls ? LSU_OP_MSG_BASE_SID : ALU_OP_MSG_OP1_SID) +: 32];
			b = d[FU_OP_BASE+(legal_ls ? LSU_OP_MSG_OFS_SID : ALU_OP_MSG_OP2_SID) +: 32];
			if (ls_f)
				addr_q.push_back(exp_result(m, a, b)); // an address rather than a register result
			else
				alu_exp[id] = exp_result(m, a, b);
		end
		if (mul)
			unit_exp[id] = mul_ref(ma, mb, d[FU_OP_BASE+MD_OP_MSG_RES_SEL_SID]);
		if (dv)
			unit_exp[id] = div_ref(ma, mb, d[INST_FLAG_REM_SID]);
	endtask

	task automatic present(input dcd_res_t d);
		issue_dcd_res = d;
		issue_id = next_id;
		issue_data = {$urandom, $urandom, $urandom, $urandom};
		issue_msg = fetch_msg_t'({$urandom, $urandom, $urandom, $urandom, $urandom});
		issue_first_after_rst = 1'($urandom);
		issue_valid = 1'b1;
	endtask

	// waits for the transfer, books it, then drops valid after the edge
	task automatic take(output int waited);
		waited = 0;
		@(negedge aclk);
		while (!issue_ready && waited < 200) begin
			waited++;
			@(negedge aclk);
		end
		if (!issue_ready)
			fail_run("issue_ready stayed low, instruction never transferred");
		note_transfer(issue_dcd_res, issue_id);
		@(posedge aclk);
		#1;
		issue_valid = 1'b0;
		next_id++;
	endtask

	// compare process
	initial begin
		forever begin
			@(negedge aclk);
			if (wb_valid) begin
				if (alu_exp.exists(wb_tid)) begin
					check_val("wb_data", wb_data, alu_exp[wb_tid]);
					alu_exp.delete(wb_tid);
				end else if (unit_exp.exists(wb_tid)) begin
					check_val("wb_data", wb_data, unit_exp[wb_tid]);
					unit_exp.delete(wb_tid);
				end else
					fail_run($sformatf("writeback for id %h that expects none", wb_tid));
			end
			if (addr_valid) begin
				if (addr_q.size() == 0)
					fail_run("address result seen with no load or store pending");
				else
					check_val("addr", addr, addr_q.pop_front());
			end
		end
	end

	initial begin
		int waited, n;
		word_t a, b;
		logic sgn, rem;
		dcd_res_t d;
		void'($urandom(67376));
		arst_n = 1'b0;
		issue_data = '0;
		issue_msg = '0;
		issue_dcd_res = '0;
		issue_id = '0;
		issue_first_after_rst = 1'b0;
		issue_valid = 1'b0;
		bru_ready = 1'b1;
		lsu_ready = 1'b1;
		next_id = '0;
		repeat (4) @(posedge aclk);
		#1;
		arst_n = 1'b1;
		@(posedge aclk);
		#1;

		for (int i = 0; i < 42; i++) begin // every mode three times
			a = $urandom;
			b = (i % 3 == 0) ? $urandom % 40 : $urandom;
			if (i % 7 == 2)
				b = a;
			present(alu_dcd(alu_mode_t'(i % 14), a, b));
			take(waited);
		end

		for (int i = 0; i < 12; i++) begin
			present(md_dcd(INST_FLAG_MUL_SID, ext($urandom, 1'($urandom)),
				ext($urandom, 1'($urandom)), 1'(i)));
			take(waited);
			if (i == 1 && waited != 0)
				fail_run("multiplier did not take a second instruction back to back");
		end

		for (int i = 0; i < 12; i++) begin
			rem = 1'(i);
			sgn = 1'(i >> 1);
			a = $urandom;
			b = $urandom >> (i % 20);
			if (i < 2) begin // most negative by -1
				a = 32'h8000_0000;
				b = '1;
				sgn = 1'b1;
			end
			if (i == 2 || i == 5)
				b = '0;
			present(md_dcd(rem ? INST_FLAG_REM_SID : INST_FLAG_DIV_SID, ext(a, sgn),
				ext(b, sgn), 1'b0));
			take(waited);
			if (i > 0 && waited < DIV_STEPS)
				fail_run("divider accepted a new instruction while busy");
		end

		bru_ready = 1'b0; // bru stall keeps every unit idle
		present(md_dcd(INST_FLAG_MUL_SID, ext($urandom, 1'b1), ext($urandom, 1'b1), 1'b1));
		repeat (5) begin
			@(negedge aclk);
			check_val("issue_ready", word_t'(issue_ready), 0);
			check_val("unit valids", word_t'({lsu_valid, DUT.mul_valid, DUT.div_valid}), 0);
		end
		@(posedge aclk);
		#1;
		bru_ready = 1'b1;
		take(waited);

		for (int i = 0; i < 6; i++) begin
			present(ls_dcd(1'(i), $urandom, $urandom, ls_type_t'($urandom_range(5, 0)),
				$urandom));
			take(waited);
		end

		for (int i = 0; i < 3; i++) begin
			d = '0;
			d[INST_FLAG_CSR_RW_SID] = 1'b1;
			d[FU_OP_BASE+CSR_OP_MSG_ADDR_SID +: 12] = csr_addr_t'($urandom);
			present(d);
			take(waited);
		end

		lsu_ready = 1'b0;
		d = alu_dcd(alu_mode_t'($urandom_range(13, 0)), $urandom, $urandom);
		d[INST_FLAG_ILLEGAL_SID] = 1'b1;
		d[INST_FLAG_LOAD_SID] = 1'b1; // would wait for the lsu if it were legal
		d[INST_FLAG_MUL_SID] = 1'b1; // flags must be ignored
		present(d);
		take(waited);
		lsu_ready = 1'b1;

		n = 0;
		while ((alu_exp.num() + unit_exp.num() + addr_q.size()) != 0 && n < 500) begin
			n++;
			@(negedge aclk);
		end
		repeat (10) @(negedge aclk); // stray writebacks would show up here
		if ((alu_exp.num() + unit_exp.num() + addr_q.size()) == 0) begin
			$display("all tests passed");
			$finish;
		end else
			fail_run("results still pending at the end of the run");
	end

endmodule

`default_nettype wire

// File: sim.f
src/exu_pkg.sv
src/dispatch.sv
src/alu.sv
src/mul_unit.sv
src/div_unit.sv
src/wb_arbiter.sv
src/exu_top.sv
tests/tb_exu.sv

// File: Makefile
# Verilator flow for the execute front testbench

TOP = tb_exu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

obj_dir/V$(TOP): sim.f src/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
